//--- logic/mult_defs.svh
// Widths for the multiplier; XLEN is fixed at 32 and the SIMD path assumes 4 lanes of 8 bits
`ifndef MULT_DEFS_SVH
`define MULT_DEFS_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------

// Register width of the host pipeline
`define MULT_XLEN 32

// Packed SIMD lanes inside one register
`define MULT_LANES 4
`define MULT_LANE_W 8

// ----------------------------------------
// Request tagging
// ----------------------------------------

// Transaction id carried from request to response
`define MULT_TID_W 3

`endif

//--- logic/mult_pkg.sv
// Types shared by the multiplier; opcode codes above OP_SMAQA are illegal and are dropped
`include "mult_defs.svh"

package mult_pkg;

  // ----------------------------------------
  // Opcodes
  // ----------------------------------------
  typedef enum logic [3:0] {
    OP_MUL    = 4'd0,
    OP_MULH   = 4'd1,
    OP_MULHU  = 4'd2,
    OP_MULHSU = 4'd3,
    OP_CLMUL  = 4'd4,
    OP_CLMULH = 4'd5,
    OP_CLMULR = 4'd6,
    OP_SMUL8  = 4'd7,
    OP_UMUL8  = 4'd8,
    OP_SMAQA  = 4'd9
  } mult_op_e;

  // ----------------------------------------
  // Request and response
  // ----------------------------------------
  typedef struct packed {
    logic                   valid;
    mult_op_e               op;
    logic [`MULT_TID_W-1:0] tid;
    logic [`MULT_XLEN-1:0]  a;
    logic [`MULT_XLEN-1:0]  b;
    logic [`MULT_XLEN-1:0]  c;
  } mult_req_t;

  typedef struct packed {
    logic                   valid;
    logic [`MULT_TID_W-1:0] tid;
    logic [`MULT_XLEN-1:0]  result;
  } mult_resp_t;

  // A set bit marks the operand as signed
  typedef struct packed {
    logic sign_a;
    logic sign_b;
  } sign_ctrl_t;

endpackage

//--- logic/mult_ctrl.sv
// Opcode decode and response stage; no back-pressure, every valid legal request answers next cycle
`include "mult_defs.svh"

module mult_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mult_pkg::mult_req_t    req_i,
  output mult_pkg::sign_ctrl_t   sign_o,
  output logic                   reverse_o,
  input  logic [2*`MULT_XLEN-1:0] prod_i,
  input  logic [`MULT_XLEN-1:0]  clmul_i,
  input  logic [`MULT_XLEN-1:0]  clmulr_i,
  input  logic [`MULT_XLEN-1:0]  lanes_i,
  input  logic [`MULT_XLEN-1:0]  dot_i,
  output mult_pkg::mult_resp_t   resp_o
);
  import mult_pkg::*;

  logic                   valid_q;
  logic [`MULT_TID_W-1:0] tid_q;
  mult_op_e               op_q;
  logic [`MULT_XLEN-1:0]  result;

  function automatic logic is_legal(input mult_op_e op);
    return op inside {OP_MUL, OP_MULH, OP_MULHU, OP_MULHSU, OP_CLMUL, OP_CLMULH,
                      OP_CLMULR, OP_SMUL8, OP_UMUL8, OP_SMAQA};
  endfunction

  // ----------------------------------------
  // Decode
  // ----------------------------------------
  always_comb begin
    sign_o = '{sign_a: 1'b0, sign_b: 1'b0};
    case (req_i.op)
      OP_MULH, OP_SMUL8: sign_o = '{sign_a: 1'b1, sign_b: 1'b1};
      // Unsigned bytes of a against signed bytes of b
      OP_SMAQA:          sign_o = '{sign_a: 1'b0, sign_b: 1'b1};
      OP_MULHSU:         sign_o = '{sign_a: 1'b1, sign_b: 1'b0};
      default:           sign_o = '{sign_a: 1'b0, sign_b: 1'b0};
    endcase
  end

  // High and reversed forms both work on bit-reversed operands
  assign reverse_o = req_i.op inside {OP_CLMULH, OP_CLMULR};

  // ----------------------------------------
  // Response stage
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      tid_q   <= '0;
      op_q    <= OP_MUL;
    end else begin
      valid_q <= req_i.valid & is_legal(req_i.op);
      tid_q   <= req_i.tid;
      op_q    <= req_i.op;
    end
  end

  // Result select on the registered opcode
  always_comb begin
    case (op_q)
      OP_MUL:                       result = prod_i[`MULT_XLEN-1:0];
      OP_MULH, OP_MULHU, OP_MULHSU: result = prod_i[2*`MULT_XLEN-1:`MULT_XLEN];
      OP_CLMUL:                     result = clmul_i;
      OP_CLMULR:                    result = clmulr_i;
      // clmulh is the reversed product moved down by one place
      OP_CLMULH:                    result = clmulr_i >> 1;
      OP_SMUL8, OP_UMUL8:           result = lanes_i;
      OP_SMAQA:                     result = dot_i;
      default:                      result = '0;
    endcase
  end

  assign resp_o.valid  = valid_q;
  assign resp_o.tid    = tid_q;
  assign resp_o.result = result;

  // ----------------------------------------
  // Assertions
  // ----------------------------------------
  a_valid_result_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    resp_o.valid |-> !$isunknown({resp_o.tid, resp_o.result})
  ) else $error("valid response carries an unknown tid or result for opcode %0d", op_q);

  a_valid_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(resp_o.valid)
  ) else $error("response valid is unknown");

endmodule

//--- logic/int_mult_unit.sv
// Full 33x33 integer product with one register stage; only the low 64 bits are kept
`include "mult_defs.svh"

module int_mult_unit (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`MULT_XLEN-1:0]   a_i,
  input  logic [`MULT_XLEN-1:0]   b_i,
  input  mult_pkg::sign_ctrl_t    sign_i,
  output logic [2*`MULT_XLEN-1:0] prod_o
);

  logic signed [`MULT_XLEN:0]     a_ext;
  logic signed [`MULT_XLEN:0]     b_ext;
  logic signed [2*`MULT_XLEN-1:0] prod_d;
  logic [2*`MULT_XLEN-1:0]        prod_q;

  // ----------------------------------------
  // Operand extension
  // ----------------------------------------

  // The extra top bit is the sign for signed operands and zero otherwise
  assign a_ext = {sign_i.sign_a & a_i[`MULT_XLEN-1], a_i};
  assign b_ext = {sign_i.sign_b & b_i[`MULT_XLEN-1], b_i};

  // Signed multiply covers all four sign combinations
  assign prod_d = a_ext * b_ext;

  // ----------------------------------------
  // Pipeline register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prod_q <= '0;
    end else begin
      prod_q <= prod_d;
    end
  end

  assign prod_o = prod_q;

endmodule

//--- logic/clmul_unit.sv
// Carry-less multiply keeping the low XLEN bits; high and reversed forms come from reversed operands
`include "mult_defs.svh"

module clmul_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [`MULT_XLEN-1:0] a_i,
  input  logic [`MULT_XLEN-1:0] b_i,
  input  logic                  reverse_i,
  output logic [`MULT_XLEN-1:0] clmul_o,
  output logic [`MULT_XLEN-1:0] clmulr_o
);

  logic [`MULT_XLEN-1:0] a_sel;
  logic [`MULT_XLEN-1:0] b_sel;
  logic [`MULT_XLEN-1:0] clmul_d;
  logic [`MULT_XLEN-1:0] clmul_q;
  logic [`MULT_XLEN-1:0] clmulr_q;

  function automatic logic [`MULT_XLEN-1:0] bit_rev(input logic [`MULT_XLEN-1:0] v);
    logic [`MULT_XLEN-1:0] r;
    for (int i = 0; i < `MULT_XLEN; i++) begin
      r[i] = v[`MULT_XLEN-1-i];
    end
    return r;
  endfunction

  // ----------------------------------------
  // Operand reversal
  // ----------------------------------------
  assign a_sel = reverse_i ? bit_rev(a_i) : a_i;
  assign b_sel = reverse_i ? bit_rev(b_i) : b_i;

  // XOR of shifted copies of a, one per set bit of b
  always_comb begin
    clmul_d = '0;
    for (int i = 0; i < `MULT_XLEN; i++) begin
      if (b_sel[i]) begin
        clmul_d = clmul_d ^ (a_sel << i);
      end
    end
  end

  // ----------------------------------------
  // Pipeline register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clmul_q  <= '0;
      clmulr_q <= '0;
    end else begin
      clmul_q  <= clmul_d;
      clmulr_q <= bit_rev(clmul_d);
    end
  end

  assign clmul_o  = clmul_q;
  assign clmulr_o = clmulr_q;

  // A unit operand b passes operand a through unchanged
  a_clmul_identity : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $past(b_sel) == 'd1 |-> clmul_o == $past(a_sel)
  ) else $error("clmul output differs from operand a for a unit operand b");

endmodule

//--- logic/simd_dot_unit.sv
// Four 8-bit lane products; the dot sum is only meaningful for mixed or signed lane products
`include "mult_defs.svh"

module simd_dot_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [`MULT_XLEN-1:0] a_i,
  input  logic [`MULT_XLEN-1:0] b_i,
  input  logic [`MULT_XLEN-1:0] c_i,
  input  mult_pkg::sign_ctrl_t  sign_i,
  output logic [`MULT_XLEN-1:0] lanes_o,
  output logic [`MULT_XLEN-1:0] dot_o
);

  localparam int unsigned LaneW = `MULT_LANE_W;
  localparam int unsigned ProdW = 2 * `MULT_LANE_W;

  logic [`MULT_LANES-1:0][ProdW-1:0] lane_prod;
  logic [`MULT_XLEN-1:0]             lanes_d;
  logic [`MULT_XLEN-1:0]             dot_d;
  logic [`MULT_XLEN-1:0]             lanes_q;
  logic [`MULT_XLEN-1:0]             dot_q;

  // ----------------------------------------
  // Lane multipliers
  // ----------------------------------------
  for (genvar l = 0; l < `MULT_LANES; l++) begin : gen_lane
    logic signed [LaneW:0] a_ext;
    logic signed [LaneW:0] b_ext;

    // 9-bit extension picks signed or unsigned per operand
    assign a_ext = {sign_i.sign_a & a_i[l*LaneW+LaneW-1], a_i[l*LaneW +: LaneW]};
    assign b_ext = {sign_i.sign_b & b_i[l*LaneW+LaneW-1], b_i[l*LaneW +: LaneW]};

    assign lane_prod[l] = a_ext * b_ext;
  end

  // Packed result holds the two low lanes
  assign lanes_d = {lane_prod[1], lane_prod[0]};

  // ----------------------------------------
  // Accumulation
  // ----------------------------------------
  always_comb begin
    dot_d = c_i;
    for (int l = 0; l < `MULT_LANES; l++) begin
      dot_d = dot_d + {{(`MULT_XLEN-ProdW){lane_prod[l][ProdW-1]}}, lane_prod[l]};
    end
  end

  // ----------------------------------------
  // Pipeline register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lanes_q <= '0;
      dot_q   <= '0;
    end else begin
      lanes_q <= lanes_d;
      dot_q   <= dot_d;
    end
  end

  assign lanes_o = lanes_q;
  assign dot_o   = dot_q;

endmodule

//--- logic/mult_top.sv
// Single-cycle multiplier top; results appear one cycle after the request, no ready output
`include "mult_defs.svh"

module mult_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  mult_pkg::mult_req_t  req_i,
  output mult_pkg::mult_resp_t resp_o
);
  import mult_pkg::*;

  sign_ctrl_t              sign;
  logic                    reverse;
  logic [2*`MULT_XLEN-1:0] prod;
  logic [`MULT_XLEN-1:0]   clmul;
  logic [`MULT_XLEN-1:0]   clmulr;
  logic [`MULT_XLEN-1:0]   lanes;
  logic [`MULT_XLEN-1:0]   dot;

  // ----------------------------------------
  // Control and response stage
  // ----------------------------------------
  mult_ctrl u_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .sign_o    (sign),
    .reverse_o (reverse),
    .prod_i    (prod),
    .clmul_i   (clmul),
    .clmulr_i  (clmulr),
    .lanes_i   (lanes),
    .dot_i     (dot),
    .resp_o    (resp_o)
  );

  // ----------------------------------------
  // Datapath units
  // ----------------------------------------
  int_mult_unit u_int_mult (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .a_i    (req_i.a),
    .b_i    (req_i.b),
    .sign_i (sign),
    .prod_o (prod)
  );

  clmul_unit u_clmul (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .a_i       (req_i.a),
    .b_i       (req_i.b),
    .reverse_i (reverse),
    .clmul_o   (clmul),
    .clmulr_o  (clmulr)
  );

  simd_dot_unit u_simd_dot (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .a_i     (req_i.a),
    .b_i     (req_i.b),
    .c_i     (req_i.c),
    .sign_i  (sign),
    .lanes_o (lanes),
    .dot_o   (dot)
  );

endmodule

//--- testbench/tb_clock_gen.sv
// Free-running clock of period 40 from time zero; reset falls at time 1 and holds for 3 rising edges
module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #20 clk_o = ~clk_o;
    end
  end

  // Short high phase at time zero gives the asynchronous reset a real falling edge
  initial begin
    rst_no = 1'b1;
    #1 rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- testbench/tb_mult.sv
// Checks every opcode, tid and the one-cycle latency; needs concurrent assertion support
`include "mult_defs.svh"

module tb_mult;
  import mult_pkg::*;

  localparam int unsigned clk_period    = 40;
  localparam int unsigned num_tests     = 6;
  localparam int unsigned reqs_per_test = 60;
  localparam int unsigned margin_cycles = 50;

  logic                  clk;
  logic                  rst_n;
  mult_req_t             req;
  mult_req_t             req_q;
  mult_resp_t            resp;
  logic                  exp_valid;
  logic [`MULT_TID_W-1:0] exp_tid;
  logic [`MULT_XLEN-1:0] exp_result;
  logic [31:0]           lcg_state;
  int                    err_count;
  int                    tests_passed;
  int                    tests_failed;

  tb_clock_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  mult_top u_dut (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .req_i  (req),
    .resp_o (resp)
  );

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int sext8(input logic [7:0] v);
    return {{24{v[7]}}, v};
  endfunction

  function automatic int zext8(input logic [7:0] v);
    return {24'b0, v};
  endfunction

  // Codes past the last opcode are illegal
  function automatic logic legal_code(input logic [3:0] code);
    return code <= OP_SMAQA;
  endfunction

  function automatic logic [31:0] ref_result(input mult_req_t r);
    longint          sa;
    longint          sb;
    longint unsigned ua;
    longint unsigned ub;
    logic [63:0]     p;
    logic [63:0]     cl;
    logic [31:0]     acc;
    logic [31:0]     p0;
    logic [31:0]     p1;
    sa = longint'($signed(r.a));
    sb = longint'($signed(r.b));
    ua = {32'b0, r.a};
    ub = {32'b0, r.b};
    // The low, high and middle windows of the full product give the three forms
    cl = '0;
    for (int i = 0; i < `MULT_XLEN; i++) begin
      if (r.b[i]) begin
        cl = cl ^ (ua << i);
      end
    end
    acc = r.c;
    for (int l = 0; l < `MULT_LANES; l++) begin
      acc = acc + zext8(r.a[`MULT_LANE_W*l +: `MULT_LANE_W]) *
                  sext8(r.b[`MULT_LANE_W*l +: `MULT_LANE_W]);
    end
    case (r.op)
      OP_MUL:    p = ua * ub;
      OP_MULH:   p = sa * sb;
      OP_MULHU:  p = ua * ub;
      OP_MULHSU: p = sa * ub;
      default:   p = '0;
    endcase
    if (r.op == OP_SMUL8) begin
      p0 = sext8(r.a[7:0]) * sext8(r.b[7:0]);
      p1 = sext8(r.a[15:8]) * sext8(r.b[15:8]);
    end else begin
      p0 = zext8(r.a[7:0]) * zext8(r.b[7:0]);
      p1 = zext8(r.a[15:8]) * zext8(r.b[15:8]);
    end
    case (r.op)
      OP_MUL:                       return p[31:0];
      OP_MULH, OP_MULHU, OP_MULHSU: return p[63:32];
      OP_CLMUL:                     return cl[31:0];
      OP_CLMULH:                    return cl[63:32];
      OP_CLMULR:                    return cl[62:31];
      OP_SMUL8, OP_UMUL8:           return {p1[15:0], p0[15:0]};
      OP_SMAQA:                     return acc;
      default:                      return '0;
    endcase
  endfunction

  // Request seen by the DUT on the previous edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= '0;
    end else begin
      req_q <= req;
    end
  end

  assign exp_valid  = req_q.valid && legal_code(req_q.op);
  assign exp_tid    = req_q.tid;
  assign exp_result = ref_result(req_q);

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic log_mismatch(input string what, input logic [3:0] op,
                              input logic [31:0] expected, input logic [31:0] observed);
    mult_op_e op_e;
    op_e = mult_op_e'(op);
    err_count++;
    $display("ERROR at %0t: %s mismatch for op %s (%0d), expected %h observed %h",
             $time, what, op_e.name(), op, expected, observed);
  endtask

  a_reset_quiet : assert property (@(posedge clk) !rst_n |-> !resp.valid)
    else log_mismatch("reset valid", $sampled(req_q.op), 0, $sampled(resp.valid));

  a_valid_match : assert property (@(posedge clk) disable iff (!rst_n)
    resp.valid == exp_valid)
    else log_mismatch("valid", $sampled(req_q.op), $sampled(exp_valid), $sampled(resp.valid));

  a_tid_match : assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid |-> resp.tid == exp_tid)
    else log_mismatch("tid", $sampled(req_q.op), $sampled(exp_tid), $sampled(resp.tid));

  a_result_match : assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid |-> resp.result == exp_result)
    else log_mismatch("result", $sampled(req_q.op), $sampled(exp_result),
                      $sampled(resp.result));

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic run_test(input int unsigned num, input string name);
    int          errs_before;
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] pick;
    mult_op_e    op;
    logic        valid;
    errs_before = err_count;
    for (int i = 0; i < reqs_per_test; i++) begin
      a = lcg_next();
      b = lcg_next();
      c = lcg_next();
      pick = lcg_next();
      valid = 1'b1;
      case (num)
        1: op = mult_op_e'(4'(pick % 4));
        2: op = mult_op_e'(4'(4 + pick % 3));
        3: op = mult_op_e'(4'(7 + pick % 2));
        4: op = OP_SMAQA;
        5: begin
          // Rotate through a legal request, an illegal code and a dropped strobe
          op = mult_op_e'(4'(i % 3 == 1 ? 10 + pick % 6 : pick % 10));
          valid = (i % 3 != 2);
        end
        default: op = mult_op_e'(4'(pick % 10));
      endcase
      if (i % 4 == 0) begin
        a[31] = 1'b1;
        b[31] = 1'b1;
      end
      @(posedge clk);
      req <= '{valid: valid, op: op, tid: 3'(i), a: a, b: b, c: c};
    end
    @(posedge clk);
    req.valid <= 1'b0;
    // Last response is checked on this edge
    @(posedge clk);
    #1;
    errs = err_count - errs_before;
    if (errs == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("Test %0d %s: %s, %0d errors", num, name, errs == 0 ? "PASS" : "FAIL", errs);
  endtask

  initial begin
    req = '0;
    lcg_state = 32'hb6e9;
    err_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    wait (rst_n === 1'b1);
    run_test(1, "integer multiply");
    run_test(2, "carry-less multiply");
    run_test(3, "packed multiply");
    run_test(4, "dot product");
    run_test(5, "validity and id");
    run_test(6, "back-to-back mixing");
    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog sized from all requests plus reset and drain cycles
  initial begin
    #((num_tests * reqs_per_test + margin_cycles) * clk_period);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Verification failed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+logic
logic/mult_pkg.sv
logic/mult_ctrl.sv
logic/int_mult_unit.sv
logic/clmul_unit.sv
logic/simd_dot_unit.sv
logic/mult_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mult.sv

//--- run.sh
#!/bin/sh
# Build and run the multiplier testbench with Verilator, judge the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mult -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/Vtb_mult > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL"
  exit 1
fi
